//--- verilog/alu_pkg.sv
// ALU package with the opcode encoding and default tag widths for the execute cluster
package alu_pkg;

  // ====================
  // Opcodes
  // ====================

  // 4-bit opcode carried with each issued micro-op
  // Encodings are fixed, since the issue side and the stimulus rely on them
  typedef enum logic [3:0] {
    // Arithmetic
    ADD  = 4'd0,
    SUB  = 4'd1,
    // Bitwise logic
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    // Shifts, amount from the low five bits of the second operand
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    // Set-less-than, result is 0 or 1
    SLT  = 4'd8,
    SLTU = 4'd9,
    // Upper immediate, second operand moved up by 12
    LUI  = 4'd10
  } alu_op_e;

  // ====================
  // Tag widths
  // ====================

  // Physical destination register tag
  // 64 physical registers by default
  localparam int PREG_W_DEF = 6;

  // Reorder-buffer slot index
  // 32 in-flight entries by default
  localparam int ROB_W_DEF = 5;

endpackage

//--- verilog/alu_exe_if.sv
// ALU issue interface carrying one micro-op from the issue side into a pipe
interface alu_exe_if #(
  parameter int PREG_W = alu_pkg::PREG_W_DEF,
  parameter int ROB_W  = alu_pkg::ROB_W_DEF
) ();

  // Handshake
  logic              valid;
  logic              ready;
  // Operands, already read out of the register file
  logic [31:0]       src0;
  logic [31:0]       src1;
  logic [31:0]       imm;
  // Second operand is imm instead of src1
  logic              imm_sel;
  alu_pkg::alu_op_e  alu_op;
  // Destination tag, only written when pdest_valid
  logic [PREG_W-1:0] pdest;
  logic              pdest_valid;
  // Reorder-buffer slot to complete
  logic [ROB_W-1:0]  rob_idx;

  // Issue side drives the micro-op
  modport issuer (
    output valid, src0, src1, imm, imm_sel, alu_op, pdest, pdest_valid, rob_idx,
    input  ready
  );

  // Pipe accepts it
  modport pipe (
    input  valid, src0, src1, imm, imm_sel, alu_op, pdest, pdest_valid, rob_idx,
    output ready
  );

endinterface

//--- verilog/alu_wb_if.sv
// ALU writeback interface carrying one result from a pipe toward the arbiter
interface alu_wb_if #(
  parameter int PREG_W = alu_pkg::PREG_W_DEF,
  parameter int ROB_W  = alu_pkg::ROB_W_DEF
) ();

  // Handshake
  logic              valid;
  logic              ready;
  // Register file write enable and data
  logic              we;
  logic [31:0]       wdata;
  logic [PREG_W-1:0] pdest;
  // Reorder-buffer slot being completed
  logic [ROB_W-1:0]  rob_idx;

  // Pipe offers the result
  modport pipe (
    output valid, we, wdata, pdest, rob_idx,
    input  ready
  );

  // Arbiter takes it when granted
  modport arbiter (
    input  valid, we, wdata, pdest, rob_idx,
    output ready
  );

endinterface

//--- verilog/arithmetic_logic_unit.sv
// Arithmetic logic unit giving the combinational 32-bit result of one ALU opcode
module arithmetic_logic_unit (
  input  logic [31:0]      src0_i,
  input  logic [31:0]      src1_i,
  input  logic             signed_i,
  input  alu_pkg::alu_op_e alu_op_i,
  output logic [31:0]      res_o
);

  // ====================
  // Shared datapath
  // ====================

  logic [4:0]         shamt;
  logic [31:0]        sum;
  logic [32:0]        diff;
  logic               less;
  logic               fill;
  logic signed [32:0] shr_ext;

  // Shift amount, low five bits only
  assign shamt = src1_i[4:0];

  assign sum = src0_i + src1_i;

  // One subtractor for SUB and both compares
  // Top bit is the unsigned borrow
  assign diff = {1'b0, src0_i} - {1'b0, src1_i};

  // Signed compare
  // Differing signs decide on their own, else the difference sign
  assign less = signed_i ? ((src0_i[31] != src1_i[31]) ? src0_i[31] : diff[31])
                         : diff[32];

  // One right shifter for SRL and SRA
  // Sign bit is replicated only for the signed case
  assign fill    = signed_i & src0_i[31];
  assign shr_ext = $signed({fill, src0_i}) >>> shamt;

  // ====================
  // Result select
  // ====================

  always_comb begin
    case (alu_op_i)
      alu_pkg::ADD:  res_o = sum;
      alu_pkg::SUB:  res_o = diff[31:0];
      alu_pkg::AND:  res_o = src0_i & src1_i;
      alu_pkg::OR:   res_o = src0_i | src1_i;
      alu_pkg::XOR:  res_o = src0_i ^ src1_i;
      alu_pkg::SLL:  res_o = src0_i << shamt;
      // Fill bit already chosen by signed_i
      alu_pkg::SRL,
      alu_pkg::SRA:  res_o = shr_ext[31:0];
      alu_pkg::SLT,
      alu_pkg::SLTU: res_o = {31'b0, less};
      // Upper immediate
      alu_pkg::LUI:  res_o = src1_i << 12;
      default:       res_o = '0;
    endcase
  end

endmodule

//--- verilog/alu_pipe.sv
// ALU pipe, a two-stage valid/ready execute lane from issue to writeback
module alu_pipe #(
  parameter int PREG_W = alu_pkg::PREG_W_DEF,
  parameter int ROB_W  = alu_pkg::ROB_W_DEF
) (
  input  logic    clk,
  input  logic    rst_n,
  alu_exe_if.pipe exe,
  alu_wb_if.pipe  wb
);

  // ====================
  // Stage 1
  // ====================

  logic              s1_valid;
  logic              s1_ready;
  logic [31:0]       s1_src0;
  logic [31:0]       s1_src1;
  logic [31:0]       s1_imm;
  logic              s1_imm_sel;
  alu_pkg::alu_op_e  s1_op;
  logic [PREG_W-1:0] s1_pdest;
  logic              s1_pdest_valid;
  logic [ROB_W-1:0]  s1_rob_idx;
  logic [31:0]       s1_op2;
  logic              s1_signed;
  logic [31:0]       alu_res;

  // Stage 2 state, declared here for the ready chain
  logic              s2_valid;
  logic              s2_ready;
  logic              s2_we;
  logic [31:0]       s2_wdata;
  logic [PREG_W-1:0] s2_pdest;
  logic [ROB_W-1:0]  s2_rob_idx;

  // Empty, or the held op moves on this cycle
  assign s1_ready  = s2_ready | ~s1_valid;
  assign exe.ready = s1_ready;

  // Loads only while stage 1 can accept, so a stall never overwrites
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= exe.valid;
    end
  end

  // Micro-op payload
  always_ff @(posedge clk) begin
    if (s1_ready && exe.valid) begin
      s1_src0        <= exe.src0;
      s1_src1        <= exe.src1;
      s1_imm         <= exe.imm;
      s1_imm_sel     <= exe.imm_sel;
      s1_op          <= exe.alu_op;
      s1_pdest       <= exe.pdest;
      s1_pdest_valid <= exe.pdest_valid;
      s1_rob_idx     <= exe.rob_idx;
    end
  end

  // Second operand, immediate or register
  assign s1_op2 = s1_imm_sel ? s1_imm : s1_src1;

  // Signed compare and arithmetic shift
  assign s1_signed = (s1_op == alu_pkg::SLT) || (s1_op == alu_pkg::SRA);

  arithmetic_logic_unit i_arithmetic_logic_unit (
    .src0_i   (s1_src0),
    .src1_i   (s1_op2),
    .signed_i (s1_signed),
    .alu_op_i (s1_op),
    .res_o    (alu_res)
  );

  // ====================
  // Stage 2
  // ====================

  // Empty, or the arbiter takes the result now
  assign s2_ready = wb.ready | ~s2_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
      s2_we    <= 1'b0;
    end else if (s2_ready) begin
      s2_valid <= s1_valid;
      // No register write without a destination
      s2_we    <= s1_valid & s1_pdest_valid;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (s2_ready && s1_valid) begin
      s2_wdata   <= alu_res;
      s2_pdest   <= s1_pdest;
      s2_rob_idx <= s1_rob_idx;
    end
  end

  assign wb.valid   = s2_valid;
  assign wb.we      = s2_we;
  assign wb.wdata   = s2_wdata;
  assign wb.pdest   = s2_pdest;
  assign wb.rob_idx = s2_rob_idx;

endmodule

//--- verilog/wb_arbiter.sv
// Writeback arbiter merging two result streams round-robin into one registered port
module wb_arbiter #(
  parameter int PREG_W = alu_pkg::PREG_W_DEF,
  parameter int ROB_W  = alu_pkg::ROB_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  alu_wb_if.arbiter         in0,
  alu_wb_if.arbiter         in1,
  output logic              wb_valid_o,
  input  logic              wb_ready_i,
  output logic              wb_we_o,
  output logic [31:0]       wb_wdata_o,
  output logic [PREG_W-1:0] wb_pdest_o,
  output logic [ROB_W-1:0]  wb_rob_idx_o
);

  // ====================
  // Grant
  // ====================

  // Priority pointer, 0 favours lane 0
  logic              prio;
  logic              out_load;
  logic              grant0;
  logic              grant1;
  logic              out_valid;
  logic              out_we;
  logic [31:0]       out_wdata;
  logic [PREG_W-1:0] out_pdest;
  logic [ROB_W-1:0]  out_rob_idx;

  // Output register empty or being drained
  assign out_load = ~out_valid | wb_ready_i;

  // A lane is ready unless the other one holds priority and is valid
  assign in0.ready = out_load & (~in1.valid | ~prio);
  assign in1.ready = out_load & (~in0.valid | prio);

  // Mutually exclusive by construction
  assign grant0 = in0.valid & in0.ready;
  assign grant1 = in1.valid & in1.ready;

  // ====================
  // Output register
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      prio      <= 1'b0;
    end else begin
      if (out_load) begin
        out_valid <= grant0 | grant1;
      end
      // Last winner drops to low priority
      if (grant0) begin
        prio <= 1'b1;
      end else if (grant1) begin
        prio <= 1'b0;
      end
    end
  end

  // Granted lane payload, held until drained
  always_ff @(posedge clk) begin
    if (grant0) begin
      out_we      <= in0.we;
      out_wdata   <= in0.wdata;
      out_pdest   <= in0.pdest;
      out_rob_idx <= in0.rob_idx;
    end else if (grant1) begin
      out_we      <= in1.we;
      out_wdata   <= in1.wdata;
      out_pdest   <= in1.pdest;
      out_rob_idx <= in1.rob_idx;
    end
  end

  assign wb_valid_o   = out_valid;
  assign wb_we_o      = out_we;
  assign wb_wdata_o   = out_wdata;
  assign wb_pdest_o   = out_pdest;
  assign wb_rob_idx_o = out_rob_idx;

endmodule

//--- verilog/dual_alu_cluster.sv
// Dual ALU cluster with two issue lanes, two execute pipes and one writeback port
module dual_alu_cluster #(
  parameter int PREG_W = alu_pkg::PREG_W_DEF,
  parameter int ROB_W  = alu_pkg::ROB_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  // Issue lane 0
  input  logic              exe0_valid_i,
  output logic              exe0_ready_o,
  input  logic [31:0]       exe0_src0_i,
  input  logic [31:0]       exe0_src1_i,
  input  logic [31:0]       exe0_imm_i,
  input  logic              exe0_imm_sel_i,
  input  alu_pkg::alu_op_e  exe0_alu_op_i,
  input  logic [PREG_W-1:0] exe0_pdest_i,
  input  logic              exe0_pdest_valid_i,
  input  logic [ROB_W-1:0]  exe0_rob_idx_i,
  // Issue lane 1
  input  logic              exe1_valid_i,
  output logic              exe1_ready_o,
  input  logic [31:0]       exe1_src0_i,
  input  logic [31:0]       exe1_src1_i,
  input  logic [31:0]       exe1_imm_i,
  input  logic              exe1_imm_sel_i,
  input  alu_pkg::alu_op_e  exe1_alu_op_i,
  input  logic [PREG_W-1:0] exe1_pdest_i,
  input  logic              exe1_pdest_valid_i,
  input  logic [ROB_W-1:0]  exe1_rob_idx_i,
  // Writeback to register file and reorder buffer
  output logic              wb_valid_o,
  input  logic              wb_ready_i,
  output logic              wb_we_o,
  output logic [31:0]       wb_wdata_o,
  output logic [PREG_W-1:0] wb_pdest_o,
  output logic [ROB_W-1:0]  wb_rob_idx_o
);

  // ====================
  // Lane interfaces
  // ====================

  alu_exe_if #(.PREG_W(PREG_W), .ROB_W(ROB_W)) exe_if0 ();
  alu_exe_if #(.PREG_W(PREG_W), .ROB_W(ROB_W)) exe_if1 ();
  alu_wb_if  #(.PREG_W(PREG_W), .ROB_W(ROB_W)) wb_if0 ();
  alu_wb_if  #(.PREG_W(PREG_W), .ROB_W(ROB_W)) wb_if1 ();

  // Lane 0 issue port
  assign exe_if0.valid       = exe0_valid_i;
  assign exe_if0.src0        = exe0_src0_i;
  assign exe_if0.src1        = exe0_src1_i;
  assign exe_if0.imm         = exe0_imm_i;
  assign exe_if0.imm_sel     = exe0_imm_sel_i;
  assign exe_if0.alu_op      = exe0_alu_op_i;
  assign exe_if0.pdest       = exe0_pdest_i;
  assign exe_if0.pdest_valid = exe0_pdest_valid_i;
  assign exe_if0.rob_idx     = exe0_rob_idx_i;
  assign exe0_ready_o        = exe_if0.ready;

  // Lane 1 issue port
  assign exe_if1.valid       = exe1_valid_i;
  assign exe_if1.src0        = exe1_src0_i;
  assign exe_if1.src1        = exe1_src1_i;
  assign exe_if1.imm         = exe1_imm_i;
  assign exe_if1.imm_sel     = exe1_imm_sel_i;
  assign exe_if1.alu_op      = exe1_alu_op_i;
  assign exe_if1.pdest       = exe1_pdest_i;
  assign exe_if1.pdest_valid = exe1_pdest_valid_i;
  assign exe_if1.rob_idx     = exe1_rob_idx_i;
  assign exe1_ready_o        = exe_if1.ready;

  // ====================
  // Pipes and arbiter
  // ====================

  alu_pipe #(.PREG_W(PREG_W), .ROB_W(ROB_W)) i_alu_pipe0 (
    .clk   (clk),
    .rst_n (rst_n),
    .exe   (exe_if0.pipe),
    .wb    (wb_if0.pipe)
  );

  alu_pipe #(.PREG_W(PREG_W), .ROB_W(ROB_W)) i_alu_pipe1 (
    .clk   (clk),
    .rst_n (rst_n),
    .exe   (exe_if1.pipe),
    .wb    (wb_if1.pipe)
  );

  // Single writeback port, round-robin between lanes
  wb_arbiter #(.PREG_W(PREG_W), .ROB_W(ROB_W)) i_wb_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .in0          (wb_if0.arbiter),
    .in1          (wb_if1.arbiter),
    .wb_valid_o   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_we_o      (wb_we_o),
    .wb_wdata_o   (wb_wdata_o),
    .wb_pdest_o   (wb_pdest_o),
    .wb_rob_idx_o (wb_rob_idx_o)
  );

endmodule

//--- test/alu_checker.sv
// Writeback checker matching each result to its expected entry by reorder-buffer index
module alu_checker #(
  parameter int PREG_W = alu_pkg::PREG_W_DEF,
  parameter int ROB_W  = alu_pkg::ROB_W_DEF
) (
  input logic              clk,
  input logic              rst_n,
  input logic              wb_valid_i,
  input logic              wb_ready_i,
  input logic              wb_we_i,
  input logic [31:0]       wb_wdata_i,
  input logic [PREG_W-1:0] wb_pdest_i,
  input logic [ROB_W-1:0]  wb_rob_idx_i,
  input logic              exe0_ready_i,
  input logic              exe1_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROB_N         = 1 << ROB_W;
  localparam int DRAIN_TIMEOUT = 400;

  // ====================
  // Expected state
  // ====================

  // Expected entries, indexed by rob_idx
  logic [31:0]       exp_wdata [ROB_N];
  logic              exp_we    [ROB_N];
  logic [PREG_W-1:0] exp_pdest [ROB_N];
  bit                known     [ROB_N];
  bit                done      [ROB_N];
  // Outstanding rob_idx per lane, oldest first
  logic [ROB_W-1:0]  order0 [$];
  logic [ROB_W-1:0]  order1 [$];
  logic [ROB_W-1:0]  head;
  int                test_errors  = 0;
  int                pass_count   = 0;
  int                fail_count   = 0;
  // Cycles with an issue port stalled
  int                stall_cycles = 0;

  task automatic add_error();
    test_errors++;
  endtask

  // we must equal pdest_valid of the issued op
  task automatic expect_result(input int lane, input logic [ROB_W-1:0] rob,
                               input logic [31:0] wdata, input logic we,
                               input logic [PREG_W-1:0] pdest);
    exp_wdata[rob] = wdata;
    exp_we[rob]    = we;
    exp_pdest[rob] = pdest;
    known[rob]     = 1'b1;
    done[rob]      = 1'b0;
    if (lane == 0) begin
      order0.push_back(rob);
    end else begin
      order1.push_back(rob);
    end
  endtask

  task automatic compare_result(input logic [ROB_W-1:0] rob);
    if (wb_wdata_i !== exp_wdata[rob]) begin
      $display("ERROR wb_wdata_o rob_idx %h: got %h, expected %h", rob, wb_wdata_i,
               exp_wdata[rob]);
      test_errors++;
    end
    if (wb_we_i !== exp_we[rob]) begin
      $display("ERROR wb_we_o rob_idx %h: got %h, expected %h", rob, wb_we_i, exp_we[rob]);
      test_errors++;
    end
    if (wb_pdest_i !== exp_pdest[rob]) begin
      $display("ERROR wb_pdest_o rob_idx %h: got %h, expected %h", rob, wb_pdest_i,
               exp_pdest[rob]);
      test_errors++;
    end
    done[rob] = 1'b1;
  endtask

  // ====================
  // Writeback monitor
  // ====================

  // Each result must be the oldest outstanding one of its lane
  always @(posedge clk) begin
    if (rst_n) begin
      if (!exe0_ready_i || !exe1_ready_i) begin
        stall_cycles++;
      end
      if (wb_valid_i && wb_ready_i) begin
        if (order0.size() > 0 && order0[0] == wb_rob_idx_i) begin
          head = order0.pop_front();
          compare_result(head);
        end else if (order1.size() > 0 && order1[0] == wb_rob_idx_i) begin
          head = order1.pop_front();
          compare_result(head);
        end else if (done[wb_rob_idx_i]) begin
          $display("rob_idx %0d was written back a second time", wb_rob_idx_i);
          test_errors++;
        end else if (known[wb_rob_idx_i]) begin
          $display("rob_idx %0d was written back ahead of older results in its lane",
                   wb_rob_idx_i);
          test_errors++;
        end else begin
          $display("writeback carries rob_idx %0d, which was never issued", wb_rob_idx_i);
          test_errors++;
        end
      end
    end
  end

  // ====================
  // Per-test reporting
  // ====================

  task automatic close_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: FAIL with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Idle outputs one cycle after reset release
  task automatic check_reset();
    @(negedge clk);
    if (wb_valid_i !== 1'b0) begin
      $display("ERROR wb_valid_o after reset: got %h, expected 0", wb_valid_i);
      test_errors++;
    end
    if (exe0_ready_i !== 1'b1) begin
      $display("ERROR exe0_ready_o after reset: got %h, expected 1", exe0_ready_i);
      test_errors++;
    end
    if (exe1_ready_i !== 1'b1) begin
      $display("ERROR exe1_ready_o after reset: got %h, expected 1", exe1_ready_i);
      test_errors++;
    end
    close_test("reset");
  endtask

  task automatic finish_test(input int test_no);
    int waited;
    waited = 0;
    while ((order0.size() + order1.size()) > 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if ((order0.size() + order1.size()) > 0) begin
      $display("test %0d: %0d results never written back within %0d cycles", test_no,
               order0.size() + order1.size(), DRAIN_TIMEOUT);
      test_errors++;
      order0.delete();
      order1.delete();
    end
    close_test($sformatf("test %0d", test_no));
  endtask

  // Stall check over the whole run, then the counts
  task automatic report_summary();
    if (stall_cycles == 0) begin
      $display("exe ready never fell while writeback was stalled");
      test_errors++;
    end
    close_test("back-pressure");
    $display("tests: %0d ok, %0d failing", pass_count, fail_count);
  endtask

endmodule

//--- test/tb_dual_alu_cluster.sv
// Testbench for the dual ALU cluster that issues file stimulus under random writeback stalls
module tb_dual_alu_cluster;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PREG_W        = alu_pkg::PREG_W_DEF;
  localparam int ROB_W         = alu_pkg::ROB_W_DEF;
  // Hex words per line of the data file
  localparam int FIELDS        = 11;
  localparam int MAX_OPS       = 32;
  localparam int ISSUE_TIMEOUT = 200;

  // ====================
  // Signals
  // ====================

  logic              clk      = 1'b0;
  logic              rst_n    = 1'b0;
  logic [1:0]        exe_valid;
  logic [31:0]       exe_src0 [2];
  logic [31:0]       exe_src1 [2];
  logic [31:0]       exe_imm [2];
  logic [1:0]        exe_imm_sel;
  alu_pkg::alu_op_e  exe_op [2];
  logic [PREG_W-1:0] exe_pdest [2];
  logic [1:0]        exe_pdest_valid;
  logic [ROB_W-1:0]  exe_rob_idx [2];
  wire               exe0_ready;
  wire               exe1_ready;
  logic              wb_valid;
  logic              wb_ready = 1'b0;
  logic              wb_we;
  logic [31:0]       wb_wdata;
  logic [PREG_W-1:0] wb_pdest;
  logic [ROB_W-1:0]  wb_rob_idx;
  logic [31:0]       stim [FIELDS*MAX_OPS];
  // Stall pattern state
  logic [15:0]       lfsr     = 16'd41679;

  always #50 clk = ~clk;

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end else begin
      return state >> 1;
    end
  endfunction

  // One LFSR step per cycle from time zero
  // A low bit stalls the writeback port
  always @(negedge clk) begin
    lfsr     = lfsr_next(lfsr);
    wb_ready = lfsr[0];
  end

  dual_alu_cluster #(.PREG_W(PREG_W), .ROB_W(ROB_W)) i_dual_alu_cluster (
    .clk (clk), .rst_n (rst_n),
    .exe0_valid_i (exe_valid[0]), .exe0_ready_o (exe0_ready),
    .exe0_src0_i (exe_src0[0]), .exe0_src1_i (exe_src1[0]), .exe0_imm_i (exe_imm[0]),
    .exe0_imm_sel_i (exe_imm_sel[0]), .exe0_alu_op_i (exe_op[0]),
    .exe0_pdest_i (exe_pdest[0]), .exe0_pdest_valid_i (exe_pdest_valid[0]),
    .exe0_rob_idx_i (exe_rob_idx[0]),
    .exe1_valid_i (exe_valid[1]), .exe1_ready_o (exe1_ready),
    .exe1_src0_i (exe_src0[1]), .exe1_src1_i (exe_src1[1]), .exe1_imm_i (exe_imm[1]),
    .exe1_imm_sel_i (exe_imm_sel[1]), .exe1_alu_op_i (exe_op[1]),
    .exe1_pdest_i (exe_pdest[1]), .exe1_pdest_valid_i (exe_pdest_valid[1]),
    .exe1_rob_idx_i (exe_rob_idx[1]),
    .wb_valid_o (wb_valid), .wb_ready_i (wb_ready), .wb_we_o (wb_we),
    .wb_wdata_o (wb_wdata), .wb_pdest_o (wb_pdest), .wb_rob_idx_o (wb_rob_idx)
  );

  alu_checker #(.PREG_W(PREG_W), .ROB_W(ROB_W)) i_alu_checker (
    .clk (clk), .rst_n (rst_n),
    .wb_valid_i (wb_valid), .wb_ready_i (wb_ready), .wb_we_i (wb_we),
    .wb_wdata_i (wb_wdata), .wb_pdest_i (wb_pdest), .wb_rob_idx_i (wb_rob_idx),
    .exe0_ready_i (exe0_ready), .exe1_ready_i (exe1_ready)
  );

  // ====================
  // Stimulus
  // ====================

  // Drives one lane's ops of a test back to back
  task automatic issue_lane(input int lane, input int test_no, input int n_ops);
    int   base;
    int   waited;
    logic accepted;
    for (int i = 0; i < n_ops; i++) begin
      base = i * FIELDS;
      if (stim[base] == test_no && stim[base + 1] == lane) begin
        @(negedge clk);
        exe_valid[lane]       = 1'b1;
        exe_op[lane]          = alu_pkg::alu_op_e'(stim[base + 2][3:0]);
        exe_src0[lane]        = stim[base + 3];
        exe_src1[lane]        = stim[base + 4];
        exe_imm[lane]         = stim[base + 5];
        exe_imm_sel[lane]     = stim[base + 6][0];
        exe_pdest[lane]       = stim[base + 7][PREG_W-1:0];
        exe_pdest_valid[lane] = stim[base + 8][0];
        exe_rob_idx[lane]     = stim[base + 9][ROB_W-1:0];
        // Transfer on the first rising edge with ready high
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < ISSUE_TIMEOUT) begin
          @(posedge clk);
          accepted = (lane == 0) ? exe0_ready : exe1_ready;
          waited++;
        end
        if (!accepted) begin
          $display("lane %0d: op for rob_idx %0d not accepted within %0d cycles", lane,
                   exe_rob_idx[lane], ISSUE_TIMEOUT);
          i_alu_checker.add_error();
          break;
        end
      end
    end
    @(negedge clk);
    exe_valid[lane] = 1'b0;
  endtask

  initial begin
    int n_ops;
    int n_tests;
    int base;
    exe_valid       = '0;
    exe_imm_sel     = '0;
    exe_pdest_valid = '0;
    for (int l = 0; l < 2; l++) begin
      exe_src0[l]    = '0;
      exe_src1[l]    = '0;
      exe_imm[l]     = '0;
      exe_op[l]      = alu_pkg::ADD;
      exe_pdest[l]   = '0;
      exe_rob_idx[l] = '0;
    end
    $readmemh("test/alu_testdata.txt", stim);
    // Op count and highest test number
    n_ops   = 0;
    n_tests = 0;
    while (n_ops < MAX_OPS && !$isunknown(stim[n_ops * FIELDS])) begin
      if (stim[n_ops * FIELDS] > n_tests) begin
        n_tests = stim[n_ops * FIELDS];
      end
      n_ops++;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    i_alu_checker.check_reset();
    for (int t = 1; t <= n_tests; t++) begin
      // Expected results in issue order
      for (int i = 0; i < n_ops; i++) begin
        base = i * FIELDS;
        if (stim[base] == t) begin
          i_alu_checker.expect_result(stim[base + 1][0], stim[base + 9][ROB_W-1:0],
                                      stim[base + 10], stim[base + 8][0],
                                      stim[base + 7][PREG_W-1:0]);
        end
      end
      fork
        issue_lane(0, t, n_ops);
        issue_lane(1, t, n_ops);
      join
      i_alu_checker.finish_test(t);
    end
    i_alu_checker.report_summary();
    if (i_alu_checker.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/alu_pkg.sv
verilog/alu_exe_if.sv
verilog/alu_wb_if.sv
verilog/arithmetic_logic_unit.sv
verilog/alu_pipe.sv
verilog/wb_arbiter.sv
verilog/dual_alu_cluster.sv
test/alu_checker.sv
test/tb_dual_alu_cluster.sv

//--- test/alu_testdata.txt
// test lane op src0 src1 imm imm_sel pdest pdest_valid rob_idx expected_wdata, all hex
// op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu a lui
1 0 0 12345678 11111111 0000ffff 0 01 1 00 23456789
1 0 1 00000005 00000007 0000ffff 0 02 1 01 fffffffe
1 0 2 f0f0ff00 0ff0f0f0 0000ffff 0 03 0 02 00f0f000
1 0 3 f0f0ff00 0ff0f0f0 0000ffff 0 04 1 03 fff0fff0
1 0 4 a5a5a5a5 ffff0000 0000ffff 0 05 1 04 5a5aa5a5
1 0 5 00000001 00000024 0000ffff 0 06 1 05 00000010
1 1 6 80000000 00000004 0000ffff 0 07 1 06 08000000
1 1 7 80000000 00000004 0000ffff 0 08 1 07 f8000000
1 1 8 ffffffff 00000001 0000ffff 0 09 1 08 00000001
1 1 9 ffffffff 00000001 0000ffff 0 0a 0 09 00000000
1 1 a deadbeef 00012345 0000ffff 0 0b 1 0a 12345000
1 1 0 ffffffff 00000001 0000ffff 0 0c 1 0b 00000000
2 1 0 00000100 5555aaaa 00000023 1 10 1 0c 00000123
2 1 1 00000010 5555aaaa 00000010 1 11 1 0d 00000000
2 1 2 12345678 5555aaaa 0000ffff 1 12 1 0e 00005678
2 1 3 12340000 5555aaaa 00005678 1 13 0 0f 12345678
2 1 4 ffffffff 5555aaaa 0f0f0f0f 1 14 1 10 f0f0f0f0
2 1 5 0000000f 5555aaaa 0000001c 1 15 1 11 f0000000
2 0 6 f0000000 5555aaaa 0000003c 1 16 1 12 0000000f
2 0 7 80000010 5555aaaa 00000001 1 17 1 13 c0000008
2 0 8 00000003 5555aaaa fffffffd 1 18 1 14 00000000
2 0 9 00000003 5555aaaa fffffffd 1 19 1 15 00000001
2 0 a deadbeef 5555aaaa 000abcde 1 1a 1 16 abcde000
2 0 1 00000000 5555aaaa 00000001 1 1b 0 17 ffffffff
3 0 7 7fffffff 0000001f 00000000 0 3f 1 18 00000000
3 1 8 80000000 7fffffff 00000000 0 20 1 1f 00000001
